// ==== design/capbuf_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// capture buffer package
// sizes, read latency and shared types of the sample capture buffer
// ~~~~~~~~~~~~~~~~~~~~
package capbuf_pkg;

  // sample payload width
  localparam int SAMPLE_WIDTH = 16;

  // number of samples the ram holds
  localparam int BUFFER_DEPTH = 64;
  localparam int ADDR_WIDTH = 6;

  // depth count covers 0 up to and including BUFFER_DEPTH
  localparam int DEPTH_WIDTH = 7;

  // ram read address to read data, in cycles
  localparam int READ_LATENCY = 2;

  // readout output queue, one slot per read in flight plus the one on the bus
  localparam int QUEUE_DEPTH = READ_LATENCY + 1;
  localparam int QUEUE_PTR_WIDTH = $clog2(QUEUE_DEPTH);
  localparam int QUEUE_CNT_WIDTH = $clog2(QUEUE_DEPTH + 1);

  typedef logic [SAMPLE_WIDTH-1:0] sample_t;
  typedef logic [ADDR_WIDTH-1:0] addr_t;
  typedef logic [DEPTH_WIDTH-1:0] depth_t;

  // controller states
  // HOLD keeps the capture until a sw reset, readout may run any number of times
  typedef enum logic [2:0] {
    IDLE,
    ARMED,
    SAVING,
    HOLD,
    READOUT
  } capture_state_t;

endpackage

// ==== design/capture_ctrl.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// capture controller
// arms, starts and stops saving, writes the ram and reports the depth
// ~~~~~~~~~~~~~~~~~~~~
module capture_ctrl (
  input  logic                       ps_clk,
  input  logic                       arst_n_i,
  input  logic                       sample_valid_i,
  input  capbuf_pkg::sample_t        sample_data_i,
  input  logic                       arm_i,
  input  logic                       hw_start_i,
  input  logic                       hw_stop_i,
  input  logic                       sw_reset_i,
  input  logic                       readout_start_i,
  input  logic                       readout_done_i,
  output logic                       wr_en_o,
  output capbuf_pkg::addr_t          wr_addr_o,
  output capbuf_pkg::sample_t        wr_data_o,
  output logic                       full_o,
  output logic                       depth_valid_o,
  output capbuf_pkg::depth_t         depth_data_o,
  input  logic                       depth_ready_i,
  output logic                       readout_go_o,
  output logic                       readout_abort_o,
  output capbuf_pkg::depth_t         readout_count_o,
  output capbuf_pkg::capture_state_t state_o
);

  capbuf_pkg::capture_state_t state_q;
  capbuf_pkg::depth_t         count_q;
  logic                       hold_entry_q;
  logic                       depth_valid_q;
  logic                       go_q;
  logic                       last_slot;

  // sample written only while saving, the stop cycle's sample is dropped
  assign wr_en_o = (state_q == capbuf_pkg::SAVING) && sample_valid_i &&
                   !hw_stop_i && !sw_reset_i;
  // count doubles as the next free address, top bit only set when full
  assign wr_addr_o = count_q[capbuf_pkg::ADDR_WIDTH-1:0];
  assign wr_data_o = sample_data_i;

  // this write fills the last free slot
  assign last_slot = wr_en_o && (int'(count_q) == capbuf_pkg::BUFFER_DEPTH - 1);

  assign full_o = ((state_q == capbuf_pkg::HOLD) || (state_q == capbuf_pkg::READOUT)) &&
                  (int'(count_q) == capbuf_pkg::BUFFER_DEPTH);

  // count is frozen in HOLD and READOUT, so it serves as the depth payload
  assign depth_valid_o = depth_valid_q;
  assign depth_data_o  = count_q;

  assign readout_go_o    = go_q;
  assign readout_count_o = count_q;
  // capture reset also cancels any readout in flight
  assign readout_abort_o = sw_reset_i;
  assign state_o         = state_q;

  always_ff @(posedge ps_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q       <= capbuf_pkg::IDLE;
      count_q       <= '0;
      hold_entry_q  <= 1'b0;
      depth_valid_q <= 1'b0;
      go_q          <= 1'b0;
    end else if (sw_reset_i) begin
      // works from any state and drops a pending depth word
      state_q       <= capbuf_pkg::IDLE;
      count_q       <= '0;
      hold_entry_q  <= 1'b0;
      depth_valid_q <= 1'b0;
      go_q          <= 1'b0;
    end else begin
      hold_entry_q <= 1'b0;
      go_q         <= 1'b0;
      // depth word held until accepted
      if (depth_valid_q && depth_ready_i) begin
        depth_valid_q <= 1'b0;
      end
      // one cycle after HOLD is entered from SAVING, once per capture
      if (hold_entry_q) begin
        depth_valid_q <= 1'b1;
      end
      case (state_q)
        capbuf_pkg::IDLE: begin
          if (arm_i) begin
            state_q <= capbuf_pkg::ARMED;
            count_q <= '0;
          end
        end
        capbuf_pkg::ARMED: begin
          // start cycle's sample is not saved
          if (hw_start_i) begin
            state_q <= capbuf_pkg::SAVING;
          end
        end
        capbuf_pkg::SAVING: begin
          if (wr_en_o) begin
            count_q <= count_q + 1'b1;
          end
          if (hw_stop_i || last_slot) begin
            state_q      <= capbuf_pkg::HOLD;
            hold_entry_q <= 1'b1;
          end
        end
        capbuf_pkg::HOLD: begin
          // empty capture has nothing to read
          if (readout_start_i && (count_q != '0)) begin
            state_q <= capbuf_pkg::READOUT;
            go_q    <= 1'b1;
          end
        end
        capbuf_pkg::READOUT: begin
          if (readout_done_i) begin
            state_q <= capbuf_pkg::HOLD;
          end
        end
        default: begin
          state_q <= capbuf_pkg::IDLE;
        end
      endcase
    end
  end

endmodule

// ==== design/sample_ram.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// sample ram
// simple dual-port memory, registered read pipeline
// ~~~~~~~~~~~~~~~~~~~~
module sample_ram (
  input  logic                ps_clk,
  input  logic                wr_en_i,
  input  capbuf_pkg::addr_t   wr_addr_i,
  input  capbuf_pkg::sample_t wr_data_i,
  input  capbuf_pkg::addr_t   rd_addr_i,
  output capbuf_pkg::sample_t rd_data_o
);

  capbuf_pkg::sample_t mem [capbuf_pkg::BUFFER_DEPTH];
  // read stages, last one drives the output
  capbuf_pkg::sample_t rd_pipe [capbuf_pkg::READ_LATENCY];

  always_ff @(posedge ps_clk) begin
    if (wr_en_i) begin
      mem[wr_addr_i] <= wr_data_i;
    end
  end

  // read is always enabled, the engine tracks which stages are valid
  always_ff @(posedge ps_clk) begin
    rd_pipe[0] <= mem[rd_addr_i];
    for (int i = 1; i < capbuf_pkg::READ_LATENCY; i++) begin
      rd_pipe[i] <= rd_pipe[i-1];
    end
  end

  assign rd_data_o = rd_pipe[capbuf_pkg::READ_LATENCY-1];

endmodule

// ==== design/readout_engine.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// readout engine
// streams saved samples from the ram with back-pressure and abort
// ~~~~~~~~~~~~~~~~~~~~
module readout_engine (
  input  logic                ps_clk,
  input  logic                arst_n_i,
  input  logic                go_i,
  input  capbuf_pkg::depth_t  count_i,
  input  logic                abort_i,
  input  logic                sw_reset_i,
  output capbuf_pkg::addr_t   rd_addr_o,
  input  capbuf_pkg::sample_t rd_data_i,
  output logic                done_o,
  output logic                rd_valid_o,
  output capbuf_pkg::sample_t rd_data_o,
  output logic                rd_last_o,
  input  logic                rd_ready_i
);

  logic                                  flush;
  capbuf_pkg::depth_t                    issue_cnt_q;
  capbuf_pkg::depth_t                    total_q;
  capbuf_pkg::depth_t                    issue_base;
  capbuf_pkg::depth_t                    issue_limit;
  logic                                  issue_en;
  logic                                  issue_last;
  logic                                  credit_ok;
  int                                    inflight;
  // reads in flight, valid and last tag per stage
  logic [capbuf_pkg::READ_LATENCY-1:0]   vld_pipe_q;
  logic [capbuf_pkg::READ_LATENCY-1:0]   last_pipe_q;
  // output queue
  capbuf_pkg::sample_t                   q_data [capbuf_pkg::QUEUE_DEPTH];
  logic [capbuf_pkg::QUEUE_DEPTH-1:0]    q_last_q;
  logic [capbuf_pkg::QUEUE_PTR_WIDTH-1:0] wr_ptr_q;
  logic [capbuf_pkg::QUEUE_PTR_WIDTH-1:0] rd_ptr_q;
  logic [capbuf_pkg::QUEUE_CNT_WIDTH-1:0] occ_q;
  logic                                  push;
  logic                                  pop;
  logic                                  done_q;

  assign flush = sw_reset_i || abort_i;

  // first read goes out in the go cycle itself
  assign issue_base  = go_i ? '0 : issue_cnt_q;
  assign issue_limit = go_i ? count_i : total_q;
  assign issue_last  = (int'(issue_base) + 1) == int'(issue_limit);

  // credits: queue slots left after this cycle's pop, minus reads on their way
  always_comb begin
    inflight = 0;
    for (int i = 0; i < capbuf_pkg::READ_LATENCY; i++) begin
      inflight = inflight + int'(vld_pipe_q[i]);
    end
    credit_ok = (int'(occ_q) - int'(pop) + inflight) < capbuf_pkg::QUEUE_DEPTH;
  end

  assign issue_en  = (issue_base != issue_limit) && credit_ok && !flush;
  // issue_base stays below 64 whenever a read is issued
  assign rd_addr_o = issue_base[capbuf_pkg::ADDR_WIDTH-1:0];

  assign rd_valid_o = (occ_q != '0);
  assign rd_data_o  = q_data[rd_ptr_q];
  assign rd_last_o  = rd_valid_o && q_last_q[rd_ptr_q];

  // ram data lines up with the oldest valid stage
  assign push = vld_pipe_q[capbuf_pkg::READ_LATENCY-1] && !flush;
  assign pop  = rd_valid_o && rd_ready_i;

  assign done_o = done_q;

  always_ff @(posedge ps_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      issue_cnt_q <= '0;
      total_q     <= '0;
      vld_pipe_q  <= '0;
      wr_ptr_q    <= '0;
      rd_ptr_q    <= '0;
      occ_q       <= '0;
      done_q      <= 1'b0;
    end else if (flush) begin
      // drop queued and in-flight data, no last goes out
      issue_cnt_q <= '0;
      total_q     <= '0;
      vld_pipe_q  <= '0;
      wr_ptr_q    <= '0;
      rd_ptr_q    <= '0;
      occ_q       <= '0;
      done_q      <= 1'b1;
    end else begin
      if (go_i) begin
        total_q <= count_i;
      end
      if (go_i || issue_en) begin
        issue_cnt_q <= issue_base + capbuf_pkg::depth_t'(issue_en);
      end
      vld_pipe_q[0] <= issue_en;
      for (int i = 1; i < capbuf_pkg::READ_LATENCY; i++) begin
        vld_pipe_q[i] <= vld_pipe_q[i-1];
      end
      if (push) begin
        wr_ptr_q <= (int'(wr_ptr_q) == capbuf_pkg::QUEUE_DEPTH - 1) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (int'(rd_ptr_q) == capbuf_pkg::QUEUE_DEPTH - 1) ? '0 : rd_ptr_q + 1'b1;
      end
      occ_q  <= occ_q + push - pop;
      // transfer complete once the tagged sample leaves
      done_q <= pop && rd_last_o;
    end
  end

  // payload side of the pipe and queue
  always_ff @(posedge ps_clk) begin
    last_pipe_q[0] <= issue_last;
    for (int i = 1; i < capbuf_pkg::READ_LATENCY; i++) begin
      last_pipe_q[i] <= last_pipe_q[i-1];
    end
    if (push) begin
      q_data[wr_ptr_q]   <= rd_data_i;
      q_last_q[wr_ptr_q] <= last_pipe_q[capbuf_pkg::READ_LATENCY-1];
    end
  end

endmodule

// ==== design/capture_buffer.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// capture buffer top
// controller, sample ram and readout engine
// ~~~~~~~~~~~~~~~~~~~~
module capture_buffer (
  input  logic                       ps_clk,
  input  logic                       arst_n_i,
  input  logic                       sample_valid_i,
  input  capbuf_pkg::sample_t        sample_data_i,
  input  logic                       capture_arm_i,
  input  logic                       capture_hw_start_i,
  input  logic                       capture_hw_stop_i,
  input  logic                       capture_sw_reset_i,
  input  logic                       readout_start_i,
  input  logic                       readout_sw_reset_i,
  output logic                       capture_full_o,
  output logic                       depth_valid_o,
  output capbuf_pkg::depth_t         depth_data_o,
  input  logic                       depth_ready_i,
  output logic                       rd_valid_o,
  output capbuf_pkg::sample_t        rd_data_o,
  output logic                       rd_last_o,
  input  logic                       rd_ready_i,
  output capbuf_pkg::capture_state_t state_o
);

  // ram write side
  logic                wr_en;
  capbuf_pkg::addr_t   wr_addr;
  capbuf_pkg::sample_t wr_data;
  // ram read side
  capbuf_pkg::addr_t   rd_addr;
  capbuf_pkg::sample_t rd_data;
  // controller to engine
  logic                readout_go;
  logic                readout_abort;
  logic                readout_done;
  capbuf_pkg::depth_t  readout_count;

  capture_ctrl capture_ctrl_i (
    .ps_clk          (ps_clk),
    .arst_n_i        (arst_n_i),
    .sample_valid_i  (sample_valid_i),
    .sample_data_i   (sample_data_i),
    .arm_i           (capture_arm_i),
    .hw_start_i      (capture_hw_start_i),
    .hw_stop_i       (capture_hw_stop_i),
    .sw_reset_i      (capture_sw_reset_i),
    .readout_start_i (readout_start_i),
    .readout_done_i  (readout_done),
    .wr_en_o         (wr_en),
    .wr_addr_o       (wr_addr),
    .wr_data_o       (wr_data),
    .full_o          (capture_full_o),
    .depth_valid_o   (depth_valid_o),
    .depth_data_o    (depth_data_o),
    .depth_ready_i   (depth_ready_i),
    .readout_go_o    (readout_go),
    .readout_abort_o (readout_abort),
    .readout_count_o (readout_count),
    .state_o         (state_o)
  );

  sample_ram sample_ram_i (
    .ps_clk    (ps_clk),
    .wr_en_i   (wr_en),
    .wr_addr_i (wr_addr),
    .wr_data_i (wr_data),
    .rd_addr_i (rd_addr),
    .rd_data_o (rd_data)
  );

  readout_engine readout_engine_i (
    .ps_clk     (ps_clk),
    .arst_n_i   (arst_n_i),
    .go_i       (readout_go),
    .count_i    (readout_count),
    .abort_i    (readout_abort),
    .sw_reset_i (readout_sw_reset_i),
    .rd_addr_o  (rd_addr),
    .rd_data_i  (rd_data),
    .done_o     (readout_done),
    .rd_valid_o (rd_valid_o),
    .rd_data_o  (rd_data_o),
    .rd_last_o  (rd_last_o),
    .rd_ready_i (rd_ready_i)
  );

endmodule

// ==== bench/capture_buffer_checker.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// capture buffer checker
// handshake stability and write enable rules bound into the top level
// ~~~~~~~~~~~~~~~~~~~~
module capture_buffer_checker (
  input logic                       ps_clk,
  input logic                       arst_n_i,
  input logic                       capture_sw_reset_i,
  input logic                       readout_sw_reset_i,
  input logic                       depth_valid_i,
  input capbuf_pkg::depth_t         depth_data_i,
  input logic                       depth_ready_i,
  input logic                       rd_valid_i,
  input capbuf_pkg::sample_t        rd_data_i,
  input logic                       rd_ready_i,
  input logic                       wr_en_i,
  input capbuf_pkg::capture_state_t state_i
);

  // pending depth word leaves only by acceptance or capture reset
  depth_stable: assert property (@(posedge ps_clk) disable iff (!arst_n_i)
    (depth_valid_i && !depth_ready_i && !capture_sw_reset_i) |=>
      (depth_valid_i && $stable(depth_data_i)))
    else $error("depth word dropped or changed before it was accepted");

  // the sample must wait unless a reset flushes the readout queue
  rd_stable: assert property (@(posedge ps_clk) disable iff (!arst_n_i)
    (rd_valid_i && !rd_ready_i && !readout_sw_reset_i && !capture_sw_reset_i) |=>
      (rd_valid_i && $stable(rd_data_i)))
    else $error("readout sample dropped or changed under back-pressure");

  // ram writes only in SAVING reached through ARMED
  wr_in_saving: assert property (@(posedge ps_clk) disable iff (!arst_n_i)
    wr_en_i |-> (state_i == capbuf_pkg::SAVING) &&
      $past((state_i == capbuf_pkg::SAVING) || (state_i == capbuf_pkg::ARMED)))
    else $error("ram write enable high outside a capture window");

endmodule

bind capture_buffer capture_buffer_checker capture_buffer_checker_i (
  .ps_clk             (ps_clk),
  .arst_n_i           (arst_n_i),
  .capture_sw_reset_i (capture_sw_reset_i),
  .readout_sw_reset_i (readout_sw_reset_i),
  .depth_valid_i      (depth_valid_o),
  .depth_data_i       (depth_data_o),
  .depth_ready_i      (depth_ready_i),
  .rd_valid_i         (rd_valid_o),
  .rd_data_i          (rd_data_o),
  .rd_ready_i         (rd_ready_i),
  .wr_en_i            (wr_en),
  .state_i            (state_o)
);

// ==== bench/capture_buffer_tb.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// capture buffer testbench
// random captures and readouts checked against a reference model
// ~~~~~~~~~~~~~~~~~~~~
module capture_buffer_tb;

  // per scenario cycle budgets
  localparam int CAPT_LEN = 80;
  localparam int FILL_LEN = 4 * capbuf_pkg::BUFFER_DEPTH;
  localparam int READ_LEN = 4 * capbuf_pkg::BUFFER_DEPTH + 16;
  localparam int TEST_LEN = 2 * CAPT_LEN + FILL_LEN + 7 * READ_LEN + 64;
  localparam int CYCLE_LIMIT = 2 * TEST_LEN;

  logic                       ps_clk = 1'b0;
  logic                       arst_n_i;
  logic                       sample_valid_i;
  capbuf_pkg::sample_t        sample_data_i;
  logic                       capture_arm_i;
  logic                       capture_hw_start_i;
  logic                       capture_hw_stop_i;
  logic                       capture_sw_reset_i;
  logic                       readout_start_i;
  logic                       readout_sw_reset_i;
  logic                       capture_full_o;
  logic                       depth_valid_o;
  capbuf_pkg::depth_t         depth_data_o;
  logic                       depth_ready_i;
  logic                       rd_valid_o;
  capbuf_pkg::sample_t        rd_data_o;
  logic                       rd_last_o;
  logic                       rd_ready_i;
  capbuf_pkg::capture_state_t state_o;

  integer                     seed = 59044;
  int                         err_cnt = 0;
  int                         cycle_cnt = 0;
  // random rd_ready when set
  logic                       bp_en = 1'b0;
  // depth_ready held low when set
  logic                       depth_hold = 1'b0;
  // reference model state and expected stored samples
  capbuf_pkg::capture_state_t m_state = capbuf_pkg::IDLE;
  capbuf_pkg::sample_t        exp_q [$];
  // transfers seen by the monitor
  capbuf_pkg::depth_t         obs_depth [$];
  capbuf_pkg::sample_t        obs_data [$];
  logic                       obs_last [$];

  capture_buffer capture_buffer_i (.*);

  always #2 ps_clk = ~ps_clk;

  // record handshakes mid cycle since they complete on the next rising edge
  always @(negedge ps_clk) begin
    if (arst_n_i && depth_valid_o && depth_ready_i) begin
      obs_depth.push_back(depth_data_o);
    end
    if (arst_n_i && rd_valid_o && rd_ready_i) begin
      obs_data.push_back(rd_data_o);
      obs_last.push_back(rd_last_o);
    end
  end

  always @(posedge ps_clk) begin
    cycle_cnt++;
    if (cycle_cnt > CYCLE_LIMIT) begin
      $display("[ERROR] timeout after %0d cycles", cycle_cnt);
      $display("Test failed");
      $finish;
    end
  end

  task automatic check_depth(input string name, input capbuf_pkg::depth_t exp_v,
                             input capbuf_pkg::depth_t act_v);
    if (exp_v !== act_v) begin
      $display("[FAIL] %s: expected %0d, actual %0d", name, exp_v, act_v);
      err_cnt++;
    end
  endtask

  task automatic check_sample(input string name, input capbuf_pkg::sample_t exp_v,
                              input capbuf_pkg::sample_t act_v);
    if (exp_v !== act_v) begin
      $display("[FAIL] %s: expected %h, actual %h", name, exp_v, act_v);
      err_cnt++;
    end
  endtask

  task automatic check_full(input string name, input logic exp_v, input logic act_v);
    if (exp_v !== act_v) begin
      $display("[FAIL] %s full flag: expected %b, actual %b", name, exp_v, act_v);
      err_cnt++;
    end
  endtask

  task automatic check_state(input string name, input capbuf_pkg::capture_state_t exp_v,
                             input capbuf_pkg::capture_state_t act_v);
    if (exp_v !== act_v) begin
      $display("[FAIL] %s state: expected %s, actual %s", name, exp_v.name(), act_v.name());
      err_cnt++;
    end
  endtask

  task automatic report_error(input string msg);
    $display("[ERROR] %s", msg);
    err_cnt++;
  endtask

  function automatic int rand_len(input int base);
    logic [31:0] rnd;
    rnd = $random(seed);
    return base + int'(rnd[3:0]);
  endfunction

  function automatic logic last_seen();
    return (obs_last.size() != 0) && obs_last[obs_last.size()-1];
  endfunction

  task automatic clear_obs();
    obs_depth.delete();
    obs_data.delete();
    obs_last.delete();
  endtask

  // controller rules applied to the inputs the DUT samples on the next edge
  task automatic model_step(input logic arm, input logic start, input logic stop,
                            input logic srst, input logic valid,
                            input capbuf_pkg::sample_t data);
    if (srst) begin
      m_state = capbuf_pkg::IDLE;
      exp_q.delete();
    end else if (m_state == capbuf_pkg::IDLE && arm) begin
      m_state = capbuf_pkg::ARMED;
      exp_q.delete();
    end else if (m_state == capbuf_pkg::ARMED && start) begin
      m_state = capbuf_pkg::SAVING;
    end else if (m_state == capbuf_pkg::SAVING) begin
      // stop cycle sample is dropped
      if (valid && !stop) begin
        exp_q.push_back(data);
      end
      if (stop || exp_q.size() == capbuf_pkg::BUFFER_DEPTH) begin
        m_state = capbuf_pkg::HOLD;
      end
    end
  endtask

  // one clock of stimulus with pulses in order arm start stop srst rstart rsrst
  task automatic apply_cycle(input logic arm, input logic start, input logic stop,
                             input logic srst, input logic rstart, input logic rsrst);
    logic [31:0] rnd;
    logic [31:0] rdy;
    rnd = $random(seed);
    rdy = $random(seed);
    @(posedge ps_clk);
    sample_valid_i     <= rnd[0];
    sample_data_i      <= rnd[31:16];
    capture_arm_i      <= arm;
    capture_hw_start_i <= start;
    capture_hw_stop_i  <= stop;
    capture_sw_reset_i <= srst;
    readout_start_i    <= rstart;
    readout_sw_reset_i <= rsrst;
    // depth ready mostly high unless held off
    depth_ready_i      <= !depth_hold && (rdy[0] | rdy[1]);
    rd_ready_i         <= bp_en ? rdy[2] : 1'b1;
    model_step(arm, start, stop, srst, rnd[0], rnd[31:16]);
  endtask

  task automatic run_idle(input int n);
    repeat (n) apply_cycle(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
  endtask

  task automatic expect_depth(input string name);
    int waited;
    waited = 0;
    while (obs_depth.size() == 0 && waited < 32) begin
      run_idle(1);
      waited++;
    end
    if (obs_depth.size() == 0) begin
      report_error({name, ": depth word missing"});
    end else begin
      check_depth({name, " depth"}, capbuf_pkg::depth_t'(exp_q.size()), obs_depth.pop_front());
    end
    @(negedge ps_clk);
    if (obs_depth.size() != 0) begin
      report_error({name, ": more than one depth word"});
    end
    check_full(name, exp_q.size() == capbuf_pkg::BUFFER_DEPTH, capture_full_o);
    check_state(name, m_state, state_o);
  endtask

  // capture reset first, then arm and start, stop after len cycles or run to full
  task automatic run_capture(input string name, input logic to_full, input int len);
    apply_cycle(1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0);
    apply_cycle(1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
    apply_cycle(1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
    if (to_full) begin
      while (m_state == capbuf_pkg::SAVING) begin
        run_idle(1);
      end
    end else begin
      run_idle(len);
      apply_cycle(1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0);
    end
    expect_depth(name);
  endtask

  task automatic read_all(input string name);
    int waited;
    int n_exp;
    n_exp = (m_state == capbuf_pkg::HOLD) ? exp_q.size() : 0;
    obs_data.delete();
    obs_last.delete();
    apply_cycle(1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0);
    waited = 0;
    while (waited < ((n_exp == 0) ? 8 : READ_LEN) && !last_seen()) begin
      run_idle(1);
      waited++;
    end
    if (n_exp != 0 && !last_seen()) begin
      report_error({name, ": last flag never seen"});
    end
    // extra beats after last would show up here
    run_idle(3);
    check_depth({name, " sample count"}, capbuf_pkg::depth_t'(n_exp),
                capbuf_pkg::depth_t'(obs_data.size()));
    for (int i = 0; i < obs_data.size() && i < n_exp; i++) begin
      check_sample($sformatf("%s[%0d]", name, i), exp_q[i], obs_data[i]);
      if (obs_last[i] !== (i == n_exp - 1)) begin
        report_error($sformatf("%s: last flag wrong on sample %0d", name, i));
      end
    end
  endtask

  // readout reset after a few beats stops the stream with no last
  task automatic abort_readout(input string name);
    int waited;
    int n_seen;
    obs_data.delete();
    obs_last.delete();
    apply_cycle(1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0);
    waited = 0;
    while (obs_data.size() < 4 && waited < READ_LEN) begin
      run_idle(1);
      waited++;
    end
    apply_cycle(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1);
    run_idle(4);
    n_seen = obs_data.size();
    run_idle(8);
    if (obs_data.size() != n_seen) begin
      report_error({name, ": samples still streaming after readout reset"});
    end
    foreach (obs_last[i]) begin
      if (obs_last[i]) begin
        report_error({name, ": last flag sent on an aborted readout"});
      end
    end
  endtask

  // expects no depth word or readout data and state and full flag as in the model
  task automatic expect_quiet(input string name);
    run_idle(6);
    @(negedge ps_clk);
    if (obs_depth.size() != 0) begin
      report_error({name, ": unexpected depth word"});
    end
    if (obs_data.size() != 0) begin
      report_error({name, ": unexpected readout data"});
    end
    check_state(name, m_state, state_o);
    check_full(name, 1'b0, capture_full_o);
  endtask

  initial begin
    arst_n_i           = 1'b0;
    sample_valid_i     = 1'b0;
    sample_data_i      = '0;
    capture_arm_i      = 1'b0;
    capture_hw_start_i = 1'b0;
    capture_hw_stop_i  = 1'b0;
    capture_sw_reset_i = 1'b0;
    readout_start_i    = 1'b0;
    readout_sw_reset_i = 1'b0;
    depth_ready_i      = 1'b0;
    rd_ready_i         = 1'b0;
    repeat (2) @(posedge ps_clk);
    arst_n_i <= 1'b1;

    // stop ended capture, then readout
    run_capture("stop_capture", 1'b0, rand_len(20));
    read_all("stop_capture");

    // run until full, then readout with and without back-pressure
    run_capture("full_capture", 1'b1, 0);
    read_all("full_capture");
    bp_en = 1'b1;
    read_all("backpressure");
    read_all("backpressure_repeat");
    bp_en = 1'b0;

    // start without arm and readout start in IDLE do nothing
    apply_cycle(1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0);
    clear_obs();
    apply_cycle(1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
    apply_cycle(1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0);
    expect_quiet("no_arm");

    // capture reset while armed, saving and holding
    apply_cycle(1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
    apply_cycle(1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0);
    expect_quiet("reset_armed");
    apply_cycle(1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
    apply_cycle(1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
    run_idle(6);
    apply_cycle(1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0);
    expect_quiet("reset_saving");
    apply_cycle(1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
    apply_cycle(1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
    run_idle(6);
    // depth word still pending when the reset lands
    depth_hold = 1'b1;
    apply_cycle(1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0);
    run_idle(2);
    apply_cycle(1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0);
    depth_hold = 1'b0;
    expect_quiet("reset_hold");

    // fresh capture, aborted readout, then a full readout again
    run_capture("after_reset", 1'b0, rand_len(24));
    read_all("after_reset");
    abort_readout("readout_reset");
    read_all("after_readout_reset");

    $display("errors: %0d", err_cnt);
    if (err_cnt == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== capture_buffer.f ====
design/capbuf_pkg.sv
design/capture_ctrl.sv
design/sample_ram.sv
design/readout_engine.sv
design/capture_buffer.sv
bench/capture_buffer_checker.sv
bench/capture_buffer_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build with verilator, run, and pass only when the pass message is printed
verilator --binary --timing --assert -Wno-fatal --top-module capture_buffer_tb \
  -f capture_buffer.f -o capture_buffer_sim \
  && ./obj_dir/capture_buffer_sim | tee /dev/stderr | grep -q "Test completed successfully" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
